// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module tb_top
	./obj_dir/Vtb_top | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dispatch_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "iq_settings.svh"

module dispatch_ctrl (
    input  wire                   clk,
    input  wire                   rst,
    input  wire iq_pkg::inst_t    head,
    input  wire                   not_empty,
    output logic                  pop,
    output logic                  alloc,
    input  wire [`ROB_TAG_W-1:0]  alloc_tag,
    input  wire                   rob_full,
    input  wire                   exec_full,
    input  wire                   retire_valid,
    input  wire iq_pkg::retire_t  retire,
    output logic                  issue_valid,
    output iq_pkg::issue_t        issue
);

    logic [`NUM_REGS-1:0]  busy_regs;  // one bit per register with a result still in flight
    logic                  rs1_busy;
    logic                  rs2_busy;
    logic                  raw_hazard;
    logic                  waw_hazard;
    logic                  res_stall;
    logic                  dispatch;

    // ##########################################################
    // stall decision
    // ##########################################################

    assign rs1_busy   = busy_regs[head.rs1];
    assign rs2_busy   = !head.has_imm && busy_regs[head.rs2];  // an immediate replaces rs2
    assign raw_hazard = rs1_busy || rs2_busy;
    assign waw_hazard = busy_regs[head.rd];

    assign res_stall  = rob_full || exec_full;

    assign dispatch = not_empty && !res_stall && !raw_hazard && !waw_hazard;

    assign pop   = dispatch;
    assign alloc = dispatch;  // rob slot is claimed in the same cycle as the pop

    // ##########################################################
    // scoreboard
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy_regs <= '0;
        end else begin
            if (retire_valid) begin
                busy_regs[retire.rd] <= 1'b0;
            end
            if (dispatch) begin
                busy_regs[head.rd] <= 1'b1;
            end
        end
    end

    // the waw check keeps a retiring rd from being dispatched again in the same cycle,
    // so the two updates above never hit the same bit

    // ##########################################################
    // issue register
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= dispatch;  // one cycle after the pop
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            issue.inst <= head;
            issue.tag  <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// ==== dispatch_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "iq_settings.svh"

module dispatch_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire iq_pkg::inst_t    in_inst,
    output logic                  iq_full,
    input  wire                   exec_full,
    output logic                  issue_valid,
    output iq_pkg::issue_t        issue,
    input  wire                   done_valid,
    input  wire [`ROB_TAG_W-1:0]  done_tag,
    output logic                  retire_valid,
    output iq_pkg::retire_t       retire
);

    logic                   push;
    iq_pkg::inst_t          iq_head;
    logic                   iq_not_empty;
    logic                   iq_pop;
    logic                   rob_alloc;
    logic [`ROB_TAG_W-1:0]  rob_alloc_tag;
    logic                   rob_full;

    assign push = (in_inst.op != `OP_NOP);  // the no-op opcode doubles as the valid flag

    ring_fifo #(
        .payload_t (iq_pkg::inst_t),
        .DEPTH     (`IQ_DEPTH)
    ) iq0 (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .push_data   (in_inst),
        .pop         (iq_pop),
        .head_data   (iq_head),
        .not_empty   (iq_not_empty),
        .almost_full (iq_full)
    );

    dispatch_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .head         (iq_head),
        .not_empty    (iq_not_empty),
        .pop          (iq_pop),
        .alloc        (rob_alloc),
        .alloc_tag    (rob_alloc_tag),
        .rob_full     (rob_full),
        .exec_full    (exec_full),
        .retire_valid (retire_valid),
        .retire       (retire),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

    reorder_buf rob0 (
        .clk          (clk),
        .rst          (rst),
        .alloc        (rob_alloc),
        .alloc_rd     (iq_head.rd),  // rd of the instruction being dispatched
        .alloc_tag    (rob_alloc_tag),
        .rob_full     (rob_full),
        .done_valid   (done_valid),
        .done_tag     (done_tag),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== iq_pkg.sv ====
`default_nettype none
`include "iq_settings.svh"

package iq_pkg;

    // ##########################################################
    // decoded instruction as it enters the queue
    // ##########################################################

    typedef struct packed {
        logic [4:0]            op;       // OP_NOP means no instruction
        logic [`REG_W-1:0]     rs1;
        logic [`REG_W-1:0]     rs2;      // ignored when has_imm is set
        logic [`REG_W-1:0]     rd;
        logic [31:0]           imm;
        logic                  has_imm;
    } inst_t;

    // ##########################################################
    // dispatch and retirement records
    // ##########################################################

    typedef struct packed {
        inst_t                 inst;
        logic [`ROB_TAG_W-1:0] tag;      // rob slot that tracks this instruction
    } issue_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`REG_W-1:0]     rd;       // register whose scoreboard bit gets released
    } retire_t;

endpackage

`default_nettype wire

// ==== iq_settings.svh ====
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// ##########################################################
// queue and buffer sizes
// ##########################################################

`define IQ_DEPTH   16     // instruction queue entries
`define ROB_DEPTH  8      // reorder buffer entries
`define ROB_TAG_W  3      // enough bits to name every rob entry

// ##########################################################
// instruction fields
// ##########################################################

`define REG_W      5      // register index width
`define NUM_REGS   32     // registers tracked by the scoreboard
`define OP_NOP     5'h1f  // all ones marks an empty input slot

`endif

// ==== iq_stim.txt ====
// first word is the number of instruction lines, then one instruction per line, all hex
// columns: test op rs1 rs2 rd imm has_imm delay (op 1f is an empty slot that never issues)
1a
1 01 02 03 04 00000010 1 03
1 1f 00 00 00 00000000 0 00
1 02 05 06 07 deadbeef 0 02
2 03 04 00 08 00000001 1 0a
2 04 08 09 0a 00000000 0 02
2 05 0b 08 08 00000000 0 01
3 07 10 11 12 00000000 0 14
3 08 13 14 15 00000000 0 01
4 0a 19 1a 1b 00000000 0 01
4 0b 1c 1d 1e 12345678 1 01
5 0c 00 00 01 00000000 0 28
5 0d 01 02 02 00000101 1 02
5 0e 01 03 03 00000102 1 01
5 0f 01 04 04 00000103 1 03
5 10 01 05 05 00000104 1 01
5 11 01 06 06 00000105 1 02
5 12 01 07 07 00000106 1 01
5 13 01 08 08 00000107 1 03
5 14 01 09 09 00000108 1 01
5 15 01 0a 0a 00000109 1 02
5 16 01 0b 0b 0000010a 1 01
5 17 01 0c 0c 0000010b 1 03
5 18 01 0d 0d 0000010c 1 01
5 19 01 0e 0e 0000010d 1 02
5 1a 01 0f 0f 0000010e 1 01
5 1b 01 10 10 0000010f 1 02

// ==== reorder_buf.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "iq_settings.svh"

module reorder_buf (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   alloc,
    input  wire [`REG_W-1:0]      alloc_rd,
    output logic [`ROB_TAG_W-1:0] alloc_tag,
    output logic                  rob_full,
    input  wire                   done_valid,
    input  wire [`ROB_TAG_W-1:0]  done_tag,
    output logic                  retire_valid,
    output iq_pkg::retire_t       retire
);

    logic [`ROB_DEPTH-1:0]  busy;  // entry holds an instruction in flight
    logic [`ROB_DEPTH-1:0]  done;  // execution has reported completion
    logic [`REG_W-1:0]      rd_mem [0:`ROB_DEPTH-1];
    logic [`ROB_TAG_W-1:0]  head_ptr;
    logic [`ROB_TAG_W-1:0]  tail_ptr;
    logic                   do_alloc;
    logic                   do_retire;

    function automatic logic [`ROB_TAG_W-1:0] next_ptr(input logic [`ROB_TAG_W-1:0] ptr);
        return (ptr == `ROB_TAG_W'(`ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign alloc_tag = tail_ptr;
    assign rob_full  = busy[tail_ptr];  // tail slot still occupied means no room
    assign do_alloc  = alloc && !rob_full;
    assign do_retire = busy[head_ptr] && done[head_ptr];

    // ##########################################################
    // entry state
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (done_valid) begin
                done[done_tag] <= 1'b1;  // completions may arrive in any order
            end
            if (do_retire) begin
                busy[head_ptr] <= 1'b0;
                done[head_ptr] <= 1'b0;
                head_ptr       <= next_ptr(head_ptr);
            end
            if (do_alloc) begin
                busy[tail_ptr] <= 1'b1;
                done[tail_ptr] <= 1'b0;
                tail_ptr       <= next_ptr(tail_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            rd_mem[tail_ptr] <= alloc_rd;
        end
    end

    // ##########################################################
    // in-order retirement
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= do_retire;  // at most one per cycle
        end
    end

    always_ff @(posedge clk) begin
        if (do_retire) begin
            retire.tag <= head_ptr;
            retire.rd  <= rd_mem[head_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== ring_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module ring_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  wire            clk,
    input  wire            rst,
    input  wire            push,
    input  wire payload_t  push_data,
    input  wire            pop,
    output payload_t       head_data,
    output logic           not_empty,
    output logic           almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [0:DEPTH-1];
    logic [PTR_W-1:0]  head_ptr;
    logic [PTR_W-1:0]  tail_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && (count != CNT_W'(DEPTH));  // a push into a full array is dropped
    assign do_pop  = pop && (count != '0);

    // ##########################################################
    // storage
    // ##########################################################

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail_ptr] <= push_data;
        end
    end

    assign head_data = mem[head_ptr];  // head is visible the cycle after its push

    // ##########################################################
    // pointers and occupancy
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (do_pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the level unchanged
            endcase
        end
    end

    assign not_empty   = (count != '0);
    assign almost_full = (count >= CNT_W'(DEPTH - 1));  // one slot early so a source in flight fits

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "iq_settings.svh"

module tb_checker (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   iq_full,
    input  wire                   exec_full,
    input  wire                   issue_valid,
    input  wire iq_pkg::issue_t   issue,
    input  wire                   retire_valid,
    input  wire iq_pkg::retire_t  retire,
    output logic                  finished,
    output int                    errors
);

    localparam int STIM_WORDS = 1 + 64 * 8;

    logic [31:0]           stim [0:STIM_WORDS-1];
    iq_pkg::inst_t         exp_inst [$];  // real instructions in program order
    int                    exp_test [$];
    logic [`NUM_REGS-1:0]  pending_rd;    // registers with an issued write not yet retired
    int                    issued;
    int                    retired;
    int                    errors_before;
    int                    retired_before;
    logic                  saw_full;
    logic                  prev_exec_full;

    initial begin
        iq_pkg::inst_t inst;
        int            w;
        finished       = 1'b0;
        errors         = 0;
        pending_rd     = '0;
        issued         = 0;
        retired        = 0;
        errors_before  = 0;
        retired_before = 0;
        saw_full       = 1'b0;
        prev_exec_full = 1'b0;
        $readmemh("iq_stim.txt", stim);
        for (int i = 0; i < int'(stim[0]); i++) begin
            w            = 1 + i * 8;
            inst.op      = stim[w+1][4:0];
            inst.rs1     = stim[w+2][`REG_W-1:0];
            inst.rs2     = stim[w+3][`REG_W-1:0];
            inst.rd      = stim[w+4][`REG_W-1:0];
            inst.imm     = stim[w+5];
            inst.has_imm = stim[w+6][0];
            if (inst.op != `OP_NOP) begin
                exp_inst.push_back(inst);
                exp_test.push_back(int'(stim[w]));
            end
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic flag_busy_reg(input string name, input logic [`REG_W-1:0] r);
        if (pending_rd[r]) begin
            $display("at %0t: instruction %0d uses %s register %0d before an older write retired",
                     $time, issued, name, r);
            errors++;
        end
    endtask

    // ##########################################################
    // issue side
    // ##########################################################

    task automatic inspect_issue();
        iq_pkg::inst_t exp;
        if (prev_exec_full) begin
            $display("at %0t: issue_valid high one cycle after exec_full was high", $time);
            errors++;
        end
        if (issued >= exp_inst.size()) begin
            $display("at %0t: an instruction issued beyond the end of the stimulus", $time);
            errors++;
        end else begin
            exp = exp_inst[issued];
            compare_field("issue.inst.op", 32'(issue.inst.op), 32'(exp.op));
            compare_field("issue.inst.rs1", 32'(issue.inst.rs1), 32'(exp.rs1));
            compare_field("issue.inst.rs2", 32'(issue.inst.rs2), 32'(exp.rs2));
            compare_field("issue.inst.rd", 32'(issue.inst.rd), 32'(exp.rd));
            compare_field("issue.inst.imm", issue.inst.imm, exp.imm);
            compare_field("issue.inst.has_imm", 32'(issue.inst.has_imm), 32'(exp.has_imm));
            compare_field("issue.tag", 32'(issue.tag), 32'(issued % `ROB_DEPTH));
            flag_busy_reg("rs1", issue.inst.rs1);
            if (!issue.inst.has_imm) begin
                flag_busy_reg("rs2", issue.inst.rs2);
            end
            flag_busy_reg("rd", issue.inst.rd);
            pending_rd[exp.rd] = 1'b1;
        end
        issued++;
    endtask

    // ##########################################################
    // retire side
    // ##########################################################

    task automatic finish_run();
        if (!saw_full) begin
            $display("iq_full never rose, so the burst did not fill the queue");
            errors++;
        end
        if (issued != retired) begin
            $display("issue count %0d does not match retire count %0d", issued, retired);
            errors++;
        end
        $display("issued %0d, retired %0d, expected %0d, errors %0d",
                 issued, retired, exp_inst.size(), errors);
        finished = 1'b1;
    endtask

    task automatic record_retire();
        if (retired >= issued) begin
            $display("at %0t: a retirement arrived with no issued instruction left", $time);
            errors++;
        end else begin
            compare_field("retire.tag", 32'(retire.tag), 32'(retired % `ROB_DEPTH));
            compare_field("retire.rd", 32'(retire.rd), 32'(exp_inst[retired].rd));
            pending_rd[exp_inst[retired].rd] = 1'b0;
            retired++;
            if (retired == exp_inst.size() || exp_test[retired] != exp_test[retired-1]) begin
                $display("test %0d finished: %0d instructions, %0d errors", exp_test[retired-1],
                         retired - retired_before, errors - errors_before);
                retired_before = retired;
                errors_before  = errors;
            end
            if (retired == exp_inst.size()) begin
                finish_run();
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (iq_full) begin
                saw_full = 1'b1;
            end
            if (issue_valid) begin
                inspect_issue();  // goes first because a release from this cycle is not visible yet
            end
            if (retire_valid) begin
                record_retire();
            end
            prev_exec_full = exec_full;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES  = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b0;  // active low from time zero
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "iq_settings.svh"

module tb_top;

    localparam int STIM_WORDS = 1 + 64 * 8;

    logic                   clk;
    logic                   rst;
    iq_pkg::inst_t          in_inst;
    logic                   iq_full;
    logic                   exec_full;
    logic                   issue_valid;
    iq_pkg::issue_t         issue;
    logic                   done_valid;
    logic [`ROB_TAG_W-1:0]  done_tag;
    logic                   retire_valid;
    iq_pkg::retire_t        retire;
    logic                   finished;
    int                     errors;

    logic [31:0]            stim [0:STIM_WORDS-1];
    iq_pkg::inst_t          nop;
    int                     delays [$];  // execution delay of each real instruction
    int                     due [0:`ROB_DEPTH-1];
    logic [`ROB_DEPTH-1:0]  pending;
    int                     cycle;
    int                     issued;
    int                     limit_ns;
    integer                 seed;
    logic                   loaded;

    tb_clk_gen clk0 (.clk(clk), .rst(rst));

    dispatch_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .in_inst      (in_inst),
        .iq_full      (iq_full),
        .exec_full    (exec_full),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .done_valid   (done_valid),
        .done_tag     (done_tag),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    tb_checker chk0 (
        .clk          (clk),
        .rst          (rst),
        .iq_full      (iq_full),
        .exec_full    (exec_full),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire       (retire),
        .finished     (finished),
        .errors       (errors)
    );

    function automatic iq_pkg::inst_t inst_at(input int w);
        iq_pkg::inst_t inst;
        inst.op      = stim[w+1][4:0];
        inst.rs1     = stim[w+2][`REG_W-1:0];
        inst.rs2     = stim[w+3][`REG_W-1:0];
        inst.rd      = stim[w+4][`REG_W-1:0];
        inst.imm     = stim[w+5];
        inst.has_imm = stim[w+6][0];
        return inst;
    endfunction

    // ##########################################################
    // stimulus
    // ##########################################################

    initial begin
        int   n;
        int   i;
        int   max_delay;
        logic room;
        nop        = '0;
        nop.op     = `OP_NOP;
        in_inst    = nop;
        exec_full  = 1'b0;
        done_valid = 1'b0;
        done_tag   = '0;
        pending    = '0;
        cycle      = 0;
        issued     = 0;
        seed       = 32'h351d0308;
        loaded     = 1'b0;
        max_delay  = 0;
        $readmemh("iq_stim.txt", stim);
        n = int'(stim[0]);
        for (int k = 0; k < n; k++) begin
            if (stim[2+k*8][4:0] != `OP_NOP) begin
                delays.push_back(int'(stim[8+k*8]));
            end
            if (int'(stim[8+k*8]) > max_delay) begin
                max_delay = int'(stim[8+k*8]);
            end
        end
        limit_ns = n * (max_delay + 20) * 20;
        loaded   = 1'b1;
        wait (rst);
        i = 0;
        while (i < n) begin
            @(negedge clk);
            room = !iq_full;  // one entry in flight still fits after the early flag
            @(posedge clk);
            if (room) begin
                in_inst <= inst_at(1 + i * 8);
                i++;
            end else begin
                in_inst <= nop;
            end
        end
        @(posedge clk);
        in_inst <= nop;
        wait (finished);
        @(posedge clk);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #(limit_ns);
        $display("watchdog expired after %0d ns with instructions still outstanding", limit_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ##########################################################
    // execution side model
    // ##########################################################

    task automatic complete_one();
        logic found;
        found = 1'b0;
        done_valid <= 1'b0;
        for (int t = 0; t < `ROB_DEPTH; t++) begin
            if (!found && pending[t] && due[t] <= cycle) begin
                found      = 1'b1;
                pending[t] = 1'b0;
                done_valid <= 1'b1;
                done_tag   <= t[`ROB_TAG_W-1:0];
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst && issue_valid && issued < delays.size()) begin
            due[issue.tag]     = cycle + delays[issued];
            pending[issue.tag] = 1'b1;
            issued++;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            exec_full  <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            cycle     <= cycle + 1;
            exec_full <= (($random(seed) & 3) == 0);  // busy about a quarter of the time
            complete_one();
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
iq_pkg.sv
ring_fifo.sv
dispatch_ctrl.sv
reorder_buf.sv
dispatch_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv
